/* common/videoPkg.sv */
package videoPkg;

	////////////////////////////////////////////////////////////
	// raster widths
	////////////////////////////////////////////////////////////

	// pixel count along a line, 0 to 383
	typedef logic [8:0] hPos_t;
	// line count in a frame, 0 to 263
	typedef logic [8:0] vPos_t;
	// scrolled coordinate, wraps at 512
	typedef logic [8:0] scroll_t;
	// tilemap address as {row[4:0], column[5:0]}
	typedef logic [10:0] tileAddr_t;
	// pixel or line offset inside one 8x8 tile
	typedef logic [2:0] fine_t;

	////////////////////////////////////////////////////////////
	// frame limits
	////////////////////////////////////////////////////////////

	localparam int hTotal = 384;
	localparam int vTotal = 264;
	localparam int hVisible = 288;
	localparam int vVisible = 224;

	// eight-pixel phase from the low bits of scrollH
	typedef enum logic [2:0] {
		phase0, phase1, phase2, phase3, phase4, phase5, phase6, phase7
	} phase_t;

	// last pixel of a tile column, where the fetch is issued
	localparam phase_t fetchPhase = phase7;

endpackage

/* common/busPkg.sv */
package busPkg;

	////////////////////////////////////////////////////////////
	// AXI4-Lite widths
	////////////////////////////////////////////////////////////

	typedef logic [3:0] axiAddr_t;
	typedef logic [31:0] axiData_t;
	typedef logic [1:0] resp_t;

	// response codes
	localparam resp_t respOkay = 2'b00;
	localparam resp_t respSlvErr = 2'b10;

	////////////////////////////////////////////////////////////
	// scroll register map
	////////////////////////////////////////////////////////////

	// byte addresses, one 32-bit word each
	localparam axiAddr_t regHScroll = 4'h0;
	localparam axiAddr_t regVScroll = 4'h4;
	localparam axiAddr_t regFlip = 4'h8;

	// write channel FSM
	typedef enum logic [1:0] {
		idle, data, resp
	} regState_t;

endpackage

/* common/scrollBusIf.sv */
`timescale 1ns/1ns

interface scrollBusIf
	import videoPkg::*;
	();

	// scrolled raster position
	scroll_t scrollH;
	scroll_t scrollV;

	// phase strobes, one cycle each, aligned with scrollH
	logic s0h;
	logic s2h;
	logic s4h;
	logic s7h;

	// position block drives everything
	modport source (
		output scrollH, scrollV, s0h, s2h, s4h, s7h
	);

	// fetch block only looks
	modport sink (
		input scrollH, scrollV, s0h, s2h, s4h, s7h
	);

endinterface

/* hw/videoTiming.sv */
`timescale 1ns/1ns

module videoTiming
	import videoPkg::*;
	(
	input logic CLK_6M,
	input logic rst,
	output hPos_t hPos,
	output vPos_t vPos,
	output logic hBlank,
	output logic vBlank
	);

	logic hWrap;
	logic vWrap;

	////////////////////////////////////////////////////////////
	// raster counters
	////////////////////////////////////////////////////////////

	// end of line and end of frame
	assign hWrap = (hPos == hPos_t'(hTotal - 1));
	assign vWrap = (vPos == vPos_t'(vTotal - 1));

	// pixel counter, free running
	always_ff @(posedge CLK_6M) begin
		if (rst) begin
			hPos <= '0;
		end else if (hWrap) begin
			hPos <= '0;
		end else begin
			hPos <= hPos + 1'b1;
		end
	end

	// line counter, steps once per line
	always_ff @(posedge CLK_6M) begin
		if (rst) begin
			vPos <= '0;
		end else if (hWrap) begin
			if (vWrap) begin
				vPos <= '0;
			end else begin
				vPos <= vPos + 1'b1;
			end
		end
	end

	// blanking straight from the visible limits
	assign hBlank = (hPos >= hPos_t'(hVisible));
	assign vBlank = (vPos >= vPos_t'(vVisible));

endmodule

/* scroll/scrollRegs.sv */
`timescale 1ns/1ns

module scrollRegs
	import videoPkg::*;
	import busPkg::*;
	(
	input logic CLK_6M,
	input logic rst,
	input axiAddr_t awaddr,
	input logic awvalid,
	output logic awready,
	input axiData_t wdata,
	input logic [3:0] wstrb,
	input logic wvalid,
	output logic wready,
	output resp_t bresp,
	output logic bvalid,
	input logic bready,
	input axiAddr_t araddr,
	input logic arvalid,
	output logic arready,
	output axiData_t rdata,
	output resp_t rresp,
	output logic rvalid,
	input logic rready,
	output scroll_t hScroll,
	output scroll_t vScroll,
	output logic flip
	);

	regState_t state;
	logic arTaken;

	////////////////////////////////////////////////////////////
	// write channel
	////////////////////////////////////////////////////////////

	// address and data taken together, ready for one cycle in data
	always_ff @(posedge CLK_6M) begin
		if (rst) begin
			state <= idle;
			awready <= 1'b0;
			wready <= 1'b0;
			bvalid <= 1'b0;
			hScroll <= '0;
			vScroll <= '0;
			flip <= 1'b0;
		end else begin
			case (state)
				idle: begin
					if (awvalid && wvalid) begin
						awready <= 1'b1;
						wready <= 1'b1;
						state <= data;
					end
				end
				data: begin
					// handshake cycle, master still holds addr and data
					awready <= 1'b0;
					wready <= 1'b0;
					bvalid <= 1'b1;
					state <= resp;
					// byte 0 holds bits 7:0, byte 1 holds bit 8
					case (awaddr)
						regHScroll: begin
							if (wstrb[0]) hScroll[7:0] <= wdata[7:0];
							if (wstrb[1]) hScroll[8] <= wdata[8];
						end
						regVScroll: begin
							if (wstrb[0]) vScroll[7:0] <= wdata[7:0];
							if (wstrb[1]) vScroll[8] <= wdata[8];
						end
						regFlip: begin
							if (wstrb[0]) flip <= wdata[0];
						end
						default: ;
					endcase
				end
				resp: begin
					// hold the response until the master takes it
					if (bready) begin
						bvalid <= 1'b0;
						state <= idle;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	// unmapped write address gets slave error
	always_ff @(posedge CLK_6M) begin
		if (state == data) begin
			if (awaddr == regHScroll || awaddr == regVScroll || awaddr == regFlip) begin
				bresp <= respOkay;
			end else begin
				bresp <= respSlvErr;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// read channel
	////////////////////////////////////////////////////////////

	assign arTaken = arvalid && arready;

	// arready one cycle, rvalid the cycle after
	always_ff @(posedge CLK_6M) begin
		if (rst) begin
			arready <= 1'b0;
			rvalid <= 1'b0;
		end else begin
			arready <= arvalid && !arready && !rvalid;
			if (arTaken) begin
				rvalid <= 1'b1;
			end else if (rvalid && rready) begin
				rvalid <= 1'b0;
			end
		end
	end

	// read data, zero for unmapped words
	always_ff @(posedge CLK_6M) begin
		if (arTaken) begin
			rresp <= respOkay;
			case (araddr)
				regHScroll: rdata <= axiData_t'(hScroll);
				regVScroll: rdata <= axiData_t'(vScroll);
				regFlip: rdata <= axiData_t'(flip);
				default: begin
					rdata <= '0;
					rresp <= respSlvErr;
				end
			endcase
		end
	end

endmodule

/* scroll/scrollPosition.sv */
`timescale 1ns/1ns

module scrollPosition
	import videoPkg::*;
	(
	input logic CLK_6M,
	input logic rst,
	input hPos_t hPos,
	input vPos_t vPos,
	input scroll_t hScroll,
	input scroll_t vScroll,
	input logic flip,
	scrollBusIf.source pos
	);

	hPos_t fH;
	hPos_t hCounter;
	scroll_t nextH;
	scroll_t nextV;
	phase_t nextPhase;
	logic [7:0] phaseDemux;

	////////////////////////////////////////////////////////////
	// flip-aware horizontal counter
	////////////////////////////////////////////////////////////

	// screen flip mirrors the pixel count
	assign fH = flip ? ~hPos : hPos;

	// low seven bits pass through the flip
	assign hCounter[6:0] = fH[6:0];
	// bit 7 skews the count on the left part of the line
	// same term both ways, since pre-flip bit 6 is ~h6 either way
	assign hCounter[7] = fH[7] ^ (~hPos[6] & ~hPos[8]);
	// bit 8 never flips
	assign hCounter[8] = ~hPos[8];

	////////////////////////////////////////////////////////////
	// scroll adders
	////////////////////////////////////////////////////////////

	// both wrap at 512, no vertical flip
	assign nextH = hScroll + scroll_t'(hCounter);
	assign nextV = vScroll + scroll_t'(vPos);

	// eight-way phase decode, one-hot
	assign nextPhase = phase_t'(nextH[2:0]);
	assign phaseDemux = 8'b0000_0001 << nextPhase;

	////////////////////////////////////////////////////////////
	// registered outputs
	////////////////////////////////////////////////////////////

	// strobes land in the same cycle as their scrollH
	// used downstream as enables on CLK_6M, not as clocks
	always_ff @(posedge CLK_6M) begin
		if (rst) begin
			pos.scrollH <= '0;
			pos.scrollV <= '0;
			pos.s0h <= 1'b0;
			pos.s2h <= 1'b0;
			pos.s4h <= 1'b0;
			pos.s7h <= 1'b0;
		end else begin
			pos.scrollH <= nextH;
			pos.scrollV <= nextV;
			pos.s0h <= phaseDemux[phase0];
			pos.s2h <= phaseDemux[phase2];
			pos.s4h <= phaseDemux[phase4];
			pos.s7h <= phaseDemux[fetchPhase];
		end
	end

endmodule

/* scroll/tilemapFetch.sv */
`timescale 1ns/1ns

module tilemapFetch
	import videoPkg::*;
	(
	input logic CLK_6M,
	input logic rst,
	scrollBusIf.sink pos,
	output tileAddr_t tileAddr,
	output fine_t fineY,
	output logic tileValid
	);

	logic [4:0] tileRow;
	logic [5:0] tileCol;

	// row from scrolled line, column from scrolled pixel
	assign tileRow = pos.scrollV[7:3];
	assign tileCol = pos.scrollH[8:3];

	////////////////////////////////////////////////////////////
	// fetch request
	////////////////////////////////////////////////////////////

	// one request per tile column, issued after the last pixel
	always_ff @(posedge CLK_6M) begin
		if (rst) begin
			tileValid <= 1'b0;
		end else begin
			tileValid <= pos.s7h;
		end
	end

	// address and fine line held between requests
	always_ff @(posedge CLK_6M) begin
		if (pos.s7h) begin
			tileAddr <= {tileRow, tileCol};
			fineY <= pos.scrollV[2:0];
		end
	end

endmodule

/* hw/scrollLayer.sv */
`timescale 1ns/1ns

module scrollLayer
	import videoPkg::*;
	import busPkg::*;
	(
	input logic CLK_6M,
	input logic rst,
	input axiAddr_t awaddr,
	input logic awvalid,
	output logic awready,
	input axiData_t wdata,
	input logic [3:0] wstrb,
	input logic wvalid,
	output logic wready,
	output resp_t bresp,
	output logic bvalid,
	input logic bready,
	input axiAddr_t araddr,
	input logic arvalid,
	output logic arready,
	output axiData_t rdata,
	output resp_t rresp,
	output logic rvalid,
	input logic rready,
	output hPos_t hPos,
	output vPos_t vPos,
	output logic hBlank,
	output logic vBlank,
	output scroll_t scrollH,
	output scroll_t scrollV,
	output tileAddr_t tileAddr,
	output fine_t fineY,
	output logic tileValid
	);

	scroll_t hScroll;
	scroll_t vScroll;
	logic flip;

	// position to fetch path
	scrollBusIf posBus ();

	// raster counters
	videoTiming timing_i (
		.CLK_6M(CLK_6M), .rst(rst),
		.hPos(hPos), .vPos(vPos), .hBlank(hBlank), .vBlank(vBlank)
	);

	// CPU side offsets and flip
	scrollRegs regs_i (
		.CLK_6M(CLK_6M), .rst(rst),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.hScroll(hScroll), .vScroll(vScroll), .flip(flip)
	);

	// scrolled position and phase strobes
	scrollPosition position_i (
		.CLK_6M(CLK_6M), .rst(rst),
		.hPos(hPos), .vPos(vPos),
		.hScroll(hScroll), .vScroll(vScroll), .flip(flip),
		.pos(posBus.source)
	);

	// tilemap address per tile column
	tilemapFetch fetch_i (
		.CLK_6M(CLK_6M), .rst(rst),
		.pos(posBus.sink),
		.tileAddr(tileAddr), .fineY(fineY), .tileValid(tileValid)
	);

	assign scrollH = posBus.scrollH;
	assign scrollV = posBus.scrollV;

endmodule

/* dv/scrollLayer_properties.sv */
`timescale 1ns/1ns

module scrollLayer_properties (
	input logic CLK_6M,
	input logic rst,
	input logic bvalid,
	input logic bready,
	input logic [8:0] scrollH,
	input logic s0h,
	input logic s2h,
	input logic s4h,
	input logic s7h,
	input logic tileValid
	);

	// write response waits for the master
	bvalidHold: assert property (@(posedge CLK_6M) disable iff (rst)
		bvalid && !bready |=> bvalid)
		else $error("bvalid dropped before bready");

	// fetch request one cycle after the phase 7 strobe
	fetchAfterS7: assert property (@(posedge CLK_6M) disable iff (rst)
		s7h |=> tileValid)
		else $error("tileValid missing after s7h");

	fetchOnlyAfterS7: assert property (@(posedge CLK_6M) disable iff (rst)
		tileValid |-> $past(s7h))
		else $error("tileValid without s7h");

	// each strobe marks its own pixel phase of scrollH
	// phases 1 3 5 6 have none, reset values are skipped
	strobePhase: assert property (@(posedge CLK_6M) disable iff (rst)
		!$past(rst) |-> ({s7h, s4h, s2h, s0h} == {scrollH[2:0] == 3'd7,
			scrollH[2:0] == 3'd4, scrollH[2:0] == 3'd2, scrollH[2:0] == 3'd0}))
		else $error("phase strobes do not match scrollH");

endmodule

bind scrollLayer scrollLayer_properties props_i (
	.CLK_6M(CLK_6M), .rst(rst), .bvalid(bvalid), .bready(bready),
	.scrollH(scrollH),
	.s0h(posBus.s0h), .s2h(posBus.s2h), .s4h(posBus.s4h), .s7h(posBus.s7h),
	.tileValid(tileValid)
);

/* dv/scrollLayerTb.sv */
`timescale 1ns/1ns

module scrollLayerTb
	import videoPkg::*;
	import busPkg::*;
	();

	logic CLK_6M;
	logic rst;
	axiAddr_t awaddr;
	logic awvalid;
	logic awready;
	axiData_t wdata;
	logic [3:0] wstrb;
	logic wvalid;
	logic wready;
	resp_t bresp;
	logic bvalid;
	logic bready;
	axiAddr_t araddr;
	logic arvalid;
	logic arready;
	axiData_t rdata;
	resp_t rresp;
	logic rvalid;
	logic rready;
	hPos_t hPos;
	vPos_t vPos;
	logic hBlank;
	logic vBlank;
	scroll_t scrollH;
	scroll_t scrollV;
	tileAddr_t tileAddr;
	fine_t fineY;
	logic tileValid;

	// stimulus table, one entry per data line
	logic [63:0] opList[$];
	logic [31:0] argList[$];
	logic [31:0] dataList[$];
	logic [31:0] expList[$];

	// shadow copy of the scroll registers
	scroll_t modelHScroll;
	scroll_t modelVScroll;
	logic modelFlip;

	logic [31:0] rngState;
	int errorCount;
	int sampleCount;
	int transferCount;
	int cycleCount = 0;
	int cycleLimit = 32'h7fff_ffff;

	scrollLayer scrollLayer_i (.*);

	initial begin
		CLK_6M = 1'b0;
		forever #20 CLK_6M = ~CLK_6M;
	end

	// watchdog
	always @(posedge CLK_6M) begin
		cycleCount = cycleCount + 1;
		if (cycleCount > cycleLimit) begin
			$display("timeout: no progress within %0d cycles", cycleLimit);
			$display("sim failed");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////

	// board horizontal counter, then the scroll add mod 512
	function automatic scroll_t expectScrollH(input hPos_t h, input logic flipOn,
		input scroll_t offset);
		logic [8:0] count;
		logic skew;
		skew = ~h[6] & ~h[8];
		if (flipOn) begin
			count[6:0] = ~h[6:0];
			count[7] = ~h[7] ^ skew;
		end else begin
			count[6:0] = h[6:0];
			count[7] = h[7] ^ skew;
		end
		count[8] = ~h[8];
		return offset + count;
	endfunction

	function automatic logic [31:0] lcgNext(input logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic resp_t expectResp(input axiAddr_t addr);
		if (addr == regHScroll || addr == regVScroll || addr == regFlip) begin
			return respOkay;
		end
		return respSlvErr;
	endfunction

	task automatic reportMismatch(input string testName, input int expected, input int actual);
		errorCount++;
		$display("[ERROR] %s expected %0h actual %0h", testName, expected, actual);
	endtask

	// registers keep bits 8:0, flip keeps bit 0
	task automatic shadowWrite(input axiAddr_t addr, input axiData_t data);
		if (addr == regHScroll) begin
			modelHScroll = data[8:0];
		end else if (addr == regVScroll) begin
			modelVScroll = data[8:0];
		end else if (addr == regFlip) begin
			modelFlip = data[0];
		end
	endtask

	////////////////////////////////////////////////////////////
	// AXI4-Lite master
	////////////////////////////////////////////////////////////

	task automatic axiWrite(input axiAddr_t addr, input axiData_t data, output resp_t resp);
		awaddr = addr;
		wdata = data;
		wstrb = 4'hF;
		awvalid = 1'b1;
		wvalid = 1'b1;
		bready = 1'b1;
		// valids stay up through the ready cycle
		do begin
			@(posedge CLK_6M);
			#2;
		end while (!(awready && wready));
		@(posedge CLK_6M);
		#2;
		awvalid = 1'b0;
		wvalid = 1'b0;
		while (!bvalid) begin
			@(posedge CLK_6M);
			#2;
		end
		resp = bresp;
		@(posedge CLK_6M);
		#2;
		bready = 1'b0;
		transferCount++;
	endtask

	task automatic axiRead(input axiAddr_t addr, output axiData_t data, output resp_t resp);
		araddr = addr;
		arvalid = 1'b1;
		rready = 1'b1;
		do begin
			@(posedge CLK_6M);
			#2;
		end while (!arready);
		@(posedge CLK_6M);
		#2;
		arvalid = 1'b0;
		while (!rvalid) begin
			@(posedge CLK_6M);
			#2;
		end
		data = rdata;
		resp = rresp;
		@(posedge CLK_6M);
		#2;
		rready = 1'b0;
		transferCount++;
	endtask

	////////////////////////////////////////////////////////////
	// raster checks
	////////////////////////////////////////////////////////////

	// predictions come from the hPos and vPos seen a cycle earlier
	task automatic sampleCheck(input int cycles);
		hPos_t lastH;
		vPos_t lastV;
		scroll_t expH;
		scroll_t expV;
		scroll_t predH;
		scroll_t predV;
		int stepH;
		int stepV;
		int depth;
		logic wantValid;
		depth = 0;
		for (int i = 0; i < cycles; i++) begin
			@(posedge CLK_6M);
			#2;
			sampleCount++;
			if (hBlank !== (hPos >= hVisible)) reportMismatch("hBlank", hPos >= hVisible, hBlank);
			if (vBlank !== (vPos >= vVisible)) reportMismatch("vBlank", vPos >= vVisible, vBlank);
			if (depth >= 1) begin
				// counters step by one and wrap at the frame size
				stepH = (lastH == hTotal - 1) ? 0 : lastH + 1;
				stepV = lastV;
				if (lastH == hTotal - 1) stepV = (lastV == vTotal - 1) ? 0 : lastV + 1;
				if (hPos !== stepH) reportMismatch("timing hPos", stepH, hPos);
				if (vPos !== stepV) reportMismatch("timing vPos", stepV, vPos);
				expH = expectScrollH(lastH, modelFlip, modelHScroll);
				expV = modelVScroll + lastV;
				if (scrollH !== expH) reportMismatch("scroll scrollH", expH, scrollH);
				if (scrollV !== expV) reportMismatch("scroll scrollV", expV, scrollV);
			end
			if (depth >= 2) begin
				// fetch follows the last pixel of a tile column
				wantValid = (predH[2:0] == 3'd7);
				if (tileValid !== wantValid) reportMismatch("fetch tileValid", wantValid, tileValid);
				if (wantValid && tileAddr !== {predV[7:3], predH[8:3]}) begin
					reportMismatch("fetch tileAddr", {predV[7:3], predH[8:3]}, tileAddr);
				end
				if (wantValid && fineY !== predV[2:0]) reportMismatch("fetch fineY", predV[2:0], fineY);
			end
			predH = expH;
			predV = expV;
			lastH = hPos;
			lastV = vPos;
			depth++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////

	initial begin
		int fd;
		int fields;
		logic [8*120-1:0] lineBuf;
		logic [63:0] opText;
		logic [31:0] argVal;
		logic [31:0] dataVal;
		logic [31:0] expVal;
		axiData_t readData;
		axiData_t randData;
		resp_t respVal;
		rst = 1'b1;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		errorCount = 0;
		sampleCount = 0;
		transferCount = 0;
		rngState = 32'd28;
		modelHScroll = '0;
		modelVScroll = '0;
		modelFlip = 1'b0;

		// comment lines fail the four-field parse
		fd = $fopen("dv/scrollStim.txt", "r");
		if (fd == 0) begin
			$display("could not open dv/scrollStim.txt");
			errorCount++;
		end else begin
			while (!$feof(fd)) begin
				if ($fgets(lineBuf, fd) != 0) begin
					fields = $sscanf(lineBuf, "%s %h %h %h", opText, argVal, dataVal, expVal);
					if (fields == 4) begin
						opList.push_back(opText);
						argList.push_back(argVal);
						dataList.push_back(dataVal);
						expList.push_back(expVal);
					end
				end
			end
			$fclose(fd);
		end
		if (fd != 0 && opList.size() == 0) begin
			$display("stimulus file holds no entries");
			errorCount++;
		end
		cycleLimit = opList.size() * 2 * hTotal + hTotal * vTotal + 8;

		repeat (8) @(posedge CLK_6M);
		#2;
		rst = 1'b0;
		if (hPos !== 0) reportMismatch("reset hPos", 0, hPos);
		if (vPos !== 0) reportMismatch("reset vPos", 0, vPos);

		foreach (opList[k]) begin
			case (opList[k])
				"write": begin
					axiWrite(argList[k][3:0], dataList[k], respVal);
					if (respVal !== expList[k][1:0]) reportMismatch("write bresp", expList[k], respVal);
					shadowWrite(argList[k][3:0], dataList[k]);
				end
				"read": begin
					axiRead(argList[k][3:0], readData, respVal);
					if (readData !== expList[k]) reportMismatch("read rdata", expList[k], readData);
					if (respVal !== expectResp(argList[k][3:0])) begin
						reportMismatch("read rresp", expectResp(argList[k][3:0]), respVal);
					end
				end
				"sample": begin
					sampleCheck(argList[k]);
				end
				"random": begin
					// mid-frame offsets, upper bits dropped by the registers
					for (int n = 0; n < argList[k]; n++) begin
						rngState = lcgNext(rngState);
						randData = {16'h0, rngState[31:16]};
						axiWrite(regHScroll, randData, respVal);
						if (respVal !== respOkay) reportMismatch("random bresp", respOkay, respVal);
						shadowWrite(regHScroll, randData);
						rngState = lcgNext(rngState);
						randData = {16'h0, rngState[31:16]};
						axiWrite(regVScroll, randData, respVal);
						if (respVal !== respOkay) reportMismatch("random bresp", respOkay, respVal);
						shadowWrite(regVScroll, randData);
						sampleCheck(dataList[k]);
					end
				end
				default: begin
					$display("unknown op in stimulus entry %0d", k);
					errorCount++;
				end
			endcase
		end

		$display("sample cycles %0d, bus transfers %0d, errors %0d",
			sampleCount, transferCount, errorCount);
		if (errorCount == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

/* dv/scrollStim.txt */
# columns are op, arg, data and expected, all hex
# write has arg as address and expected bresp, read has expected rdata
# sample has arg as cycles, random has arg as pairs and data as cycles per pair
sample    18C00   0         0
write     0       000001A5  0
read      0       0         1A5
write     0       FFFFFE37  0
read      0       0         37
write     4       00012345  0
read      4       0         145
write     8       00000003  0
read      8       0         1
write     8       00000000  0
read      8       0         0
write     C       00000055  2
read      C       0         0
read      0       0         37
read      4       0         145
sample    300     0         0
write     8       00000001  0
sample    300     0         0
read      8       0         1
random    6       40        0
sample    200     0         0

/* project.f */
common/videoPkg.sv
common/busPkg.sv
common/scrollBusIf.sv
hw/videoTiming.sv
scroll/scrollRegs.sv
scroll/scrollPosition.sv
scroll/tilemapFetch.sv
hw/scrollLayer.sv
dv/scrollLayer_properties.sv
dv/scrollLayerTb.sv
